/* rrvCorePkg.sv */
// --------------------
// Shared definitions for the RV32I control block
// Widths, NOP encoding, opcode and ALU-op enums
// Immediate-type and write-back select enums
// --------------------
`default_nettype none

package rrvCorePkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;  // Register index width

    localparam logic [XLEN-1:0] NOP = 32'h0000_0013;  // addi x0, x0, 0

    // --------------------
    // RV32I major opcodes
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        I_OP   = 7'b0010011,
        R_OP   = 7'b0110011,
        FENCE  = 7'b0001111,
        SYSCAL = 7'b1110011   // Decoded as no-op here
    } tOpcode;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } tAluOp;

    // Immediate field layouts
    typedef enum logic [2:0] {
        I_TYPE = 3'd0,
        S_TYPE = 3'd1,
        B_TYPE = 3'd2,
        U_TYPE = 3'd3,
        J_TYPE = 3'd4
    } tImmType;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_DMEM = 2'd1,
        WB_PC4  = 2'd2
    } tWbSel;

endpackage

`default_nettype wire

/* rrvDecoder.sv */
// --------------------
// Q101H instruction decoder
// Control bits, byte enables and ALU op
// Sign-extended immediate assembly
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rrvDecoder (
    input  wire  [rrvCorePkg::XLEN-1:0]       InstructionQ101H,
    output rrvCorePkg::tAluOp                 AluOpQ101H,
    output logic                              SelAluImmQ101H,
    output logic                              SelAluPcQ101H,
    output logic                              SelNextPcJQ101H,
    output logic                              SelNextPcBQ101H,
    output logic                              LuiQ101H,
    output logic                              RegWrEnQ101H,
    output logic                              DMemWrEnQ101H,
    output logic                              DMemRdEnQ101H,
    output logic                              SignExtQ101H,
    output logic [3:0]                        DMemByteEnQ101H,
    output rrvCorePkg::tWbSel                 WbSelQ101H,
    output logic [2:0]                        BranchOpQ101H,
    output logic [rrvCorePkg::REG_ADDR_W-1:0] RegDstQ101H,
    output logic [rrvCorePkg::REG_ADDR_W-1:0] RegSrc1Q101H,
    output logic [rrvCorePkg::REG_ADDR_W-1:0] RegSrc2Q101H,
    output logic [rrvCorePkg::XLEN-1:0]       ImmediateQ101H
);

    rrvCorePkg::tOpcode  opcode;
    rrvCorePkg::tImmType immType;
    logic [2:0]          funct3;
    logic                altFunct;   // funct7 bit 5, SUB and SRA
    logic                memAccess;

    assign opcode    = rrvCorePkg::tOpcode'(InstructionQ101H[6:0]);
    assign funct3    = InstructionQ101H[14:12];
    assign altFunct  = InstructionQ101H[30];
    assign memAccess = (opcode == rrvCorePkg::LOAD) || (opcode == rrvCorePkg::STORE);

    assign RegDstQ101H  = InstructionQ101H[11:7];
    assign RegSrc1Q101H = InstructionQ101H[19:15];
    assign RegSrc2Q101H = InstructionQ101H[24:20];

    // --------------------
    // Control bits
    assign SelNextPcJQ101H = (opcode == rrvCorePkg::JAL) || (opcode == rrvCorePkg::JALR);
    assign SelNextPcBQ101H = (opcode == rrvCorePkg::BRANCH);
    assign SelAluPcQ101H   = (opcode == rrvCorePkg::JAL) || (opcode == rrvCorePkg::BRANCH) ||
                             (opcode == rrvCorePkg::AUIPC);
    assign SelAluImmQ101H  = (opcode != rrvCorePkg::R_OP);  // Only reg-reg uses rs2
    assign LuiQ101H        = (opcode == rrvCorePkg::LUI);
    assign RegWrEnQ101H    = (opcode == rrvCorePkg::LUI)  || (opcode == rrvCorePkg::AUIPC) ||
                             SelNextPcJQ101H              || (opcode == rrvCorePkg::LOAD)  ||
                             (opcode == rrvCorePkg::I_OP) || (opcode == rrvCorePkg::R_OP);
    assign DMemWrEnQ101H   = (opcode == rrvCorePkg::STORE);
    assign DMemRdEnQ101H   = (opcode == rrvCorePkg::LOAD);
    assign SignExtQ101H    = DMemRdEnQ101H && !funct3[2];  // LB and LH only
    assign BranchOpQ101H   = funct3;
    assign WbSelQ101H      = SelNextPcJQ101H ? rrvCorePkg::WB_PC4  :
                             DMemRdEnQ101H   ? rrvCorePkg::WB_DMEM :
                                               rrvCorePkg::WB_ALU;
    assign DMemByteEnQ101H = !memAccess              ? 4'b0000 :
                             (funct3[1:0] == 2'b00)  ? 4'b0001 :  // Byte
                             (funct3[1:0] == 2'b01)  ? 4'b0011 :  // Half
                             (funct3[1:0] == 2'b10)  ? 4'b1111 :  // Word
                                                       4'b0000;

    // ALU op, address math by default
    always_comb begin
        AluOpQ101H = rrvCorePkg::ADD;
        if ((opcode == rrvCorePkg::R_OP) || (opcode == rrvCorePkg::I_OP)) begin
            case (funct3)
                3'b000:  AluOpQ101H = (opcode == rrvCorePkg::R_OP && altFunct) ?
                                      rrvCorePkg::SUB : rrvCorePkg::ADD;
                3'b001:  AluOpQ101H = rrvCorePkg::SLL;
                3'b010:  AluOpQ101H = rrvCorePkg::SLT;
                3'b011:  AluOpQ101H = rrvCorePkg::SLTU;
                3'b100:  AluOpQ101H = rrvCorePkg::XOR;
                3'b101:  AluOpQ101H = altFunct ? rrvCorePkg::SRA : rrvCorePkg::SRL;
                3'b110:  AluOpQ101H = rrvCorePkg::OR;
                default: AluOpQ101H = rrvCorePkg::AND;
            endcase
        end
    end

    // --------------------
    // Immediate generator
    always_comb begin
        case (opcode)
            rrvCorePkg::LUI, rrvCorePkg::AUIPC: immType = rrvCorePkg::U_TYPE;
            rrvCorePkg::JAL:                    immType = rrvCorePkg::J_TYPE;
            rrvCorePkg::BRANCH:                 immType = rrvCorePkg::B_TYPE;
            rrvCorePkg::STORE:                  immType = rrvCorePkg::S_TYPE;
            default:                            immType = rrvCorePkg::I_TYPE;
        endcase
        case (immType)
            rrvCorePkg::U_TYPE: ImmediateQ101H = {InstructionQ101H[31:12], 12'b0};
            rrvCorePkg::S_TYPE: ImmediateQ101H = {{20{InstructionQ101H[31]}},
                                    InstructionQ101H[31:25], InstructionQ101H[11:7]};
            rrvCorePkg::B_TYPE: ImmediateQ101H = {{20{InstructionQ101H[31]}},
                                    InstructionQ101H[7], InstructionQ101H[30:25],
                                    InstructionQ101H[11:8], 1'b0};
            rrvCorePkg::J_TYPE: ImmediateQ101H = {{12{InstructionQ101H[31]}},
                                    InstructionQ101H[19:12], InstructionQ101H[20],
                                    InstructionQ101H[30:21], 1'b0};
            default:            ImmediateQ101H = {{20{InstructionQ101H[31]}},
                                    InstructionQ101H[31:20]};
        endcase
    end

endmodule

`default_nettype wire

/* rrvHazard.sv */
// --------------------
// Load-use hazard detection
// Branch and jump flush over two slots
// Q101H instruction masking and stage ready enables
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rrvHazard (
    input  wire                                Clock,
    input  wire                                rstN,
    input  wire  [rrvCorePkg::XLEN-1:0]        PreInstructionQ101H,
    input  wire  [rrvCorePkg::REG_ADDR_W-1:0]  RegDstQ102H,
    input  wire                                DMemRdEnQ102H,
    input  wire  [rrvCorePkg::REG_ADDR_W-1:0]  RegDstQ103H,
    input  wire                                DMemRdEnQ103H,
    input  wire                                SelNextPcJQ102H,
    input  wire                                SelNextPcBQ102H,
    input  wire                                BranchCondMetQ102H,
    input  wire                                DMemReady,
    output logic [rrvCorePkg::XLEN-1:0]        InstructionQ101H,
    output logic                               PreValidQ101H,
    output logic                               SelNextPcAluOutQ102H,
    output logic                               ReadyQ100H,
    output logic                               ReadyQ101H,
    output logic                               ReadyQ102H,
    output logic                               ReadyQ103H,
    output logic                               ReadyQ104H,
    output logic                               ReadyQ105H
);

    logic [rrvCorePkg::REG_ADDR_W-1:0] preRegSrc1;
    logic [rrvCorePkg::REG_ADDR_W-1:0] preRegSrc2;
    logic                              loadHzrdQ102H;
    logic                              loadHzrdQ103H;
    logic                              flushQ102H;
    logic                              flushQ103H;
    logic                              killQ101H;

    assign preRegSrc1 = PreInstructionQ101H[19:15];
    assign preRegSrc2 = PreInstructionQ101H[24:20];

    // Loads in flight against the raw sources
    assign loadHzrdQ102H = DMemRdEnQ102H &&
                           ((RegDstQ102H == preRegSrc1) || (RegDstQ102H == preRegSrc2));
    assign loadHzrdQ103H = DMemRdEnQ103H &&
                           ((RegDstQ103H == preRegSrc1) || (RegDstQ103H == preRegSrc2));

    // Taken redirect resolves in Q102H
    assign flushQ102H           = SelNextPcJQ102H || (SelNextPcBQ102H && BranchCondMetQ102H);
    assign SelNextPcAluOutQ102H = flushQ102H;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            flushQ103H <= 1'b0;
        end else if (ReadyQ103H) begin
            flushQ103H <= flushQ102H;  // Second flushed slot
        end
    end

    assign killQ101H        = flushQ102H || flushQ103H || loadHzrdQ102H || loadHzrdQ103H;
    assign InstructionQ101H = killQ101H ? rrvCorePkg::NOP : PreInstructionQ101H;
    assign PreValidQ101H    = !killQ101H;

    // --------------------
    // Ready chain, freeze on DMemReady low
    assign ReadyQ105H = DMemReady;
    assign ReadyQ104H = DMemReady;
    assign ReadyQ103H = DMemReady;
    assign ReadyQ102H = DMemReady;
    assign ReadyQ101H = DMemReady && (flushQ102H || !(loadHzrdQ102H || loadHzrdQ103H));
    assign ReadyQ100H = ReadyQ101H;

    // Redirect target must always flow in while the flush runs
    assert property (@(posedge Clock) disable iff (!rstN)
        (DMemReady && (flushQ102H || flushQ103H)) |-> ReadyQ101H);

endmodule

`default_nettype wire

/* rrvCtrlPipe.sv */
// --------------------
// Control and valid registers Q102H to Q105H
// Stage-gated control outputs
// Load and redirect info for the hazard unit
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rrvCtrlPipe (
    input  wire                                Clock,
    input  wire                                rstN,
    input  wire                                ReadyQ101H,
    input  wire                                ReadyQ102H,
    input  wire                                ReadyQ103H,
    input  wire                                ReadyQ104H,
    input  wire                                ReadyQ105H,
    input  wire                                PreValidQ101H,
    input  rrvCorePkg::tAluOp                  AluOpQ101H,
    input  wire                                SelAluImmQ101H,
    input  wire                                SelAluPcQ101H,
    input  wire                                SelNextPcJQ101H,
    input  wire                                SelNextPcBQ101H,
    input  wire                                LuiQ101H,
    input  wire                                RegWrEnQ101H,
    input  wire                                DMemWrEnQ101H,
    input  wire                                DMemRdEnQ101H,
    input  wire                                SignExtQ101H,
    input  wire  [3:0]                         DMemByteEnQ101H,
    input  rrvCorePkg::tWbSel                  WbSelQ101H,
    input  wire  [2:0]                         BranchOpQ101H,
    input  wire  [rrvCorePkg::REG_ADDR_W-1:0]  RegDstQ101H,
    output rrvCorePkg::tAluOp                  AluOpQ102H,
    output logic                               SelAluImmQ102H,
    output logic                               SelAluPcQ102H,
    output logic                               LuiQ102H,
    output logic [2:0]                         BranchOpQ102H,
    output logic                               SelNextPcJQ102H,
    output logic                               SelNextPcBQ102H,
    output logic [rrvCorePkg::REG_ADDR_W-1:0]  RegDstQ102H,
    output logic                               DMemRdEnQ102H,
    output logic                               DMemWrEnQ103H,
    output logic                               DMemRdEnQ103H,
    output logic [3:0]                         DMemByteEnQ103H,
    output logic [rrvCorePkg::REG_ADDR_W-1:0]  RegDstQ103H,
    output logic                               RegWrEnQ105H,
    output logic [rrvCorePkg::REG_ADDR_W-1:0]  RegDstQ105H,
    output rrvCorePkg::tWbSel                  WbSelQ105H,
    output logic                               SignExtQ105H,
    output logic [3:0]                         ByteEnQ105H
);

    typedef struct packed {
        rrvCorePkg::tAluOp                 aluOp;
        logic                              selAluImm;
        logic                              selAluPc;
        logic                              selNextPcJ;
        logic                              selNextPcB;
        logic                              lui;
        logic                              regWrEn;
        logic                              dMemWrEn;
        logic                              dMemRdEn;
        logic                              signExt;
        logic [3:0]                        dMemByteEn;
        rrvCorePkg::tWbSel                 wbSel;
        logic [2:0]                        branchOp;
        logic [rrvCorePkg::REG_ADDR_W-1:0] regDst;
    } tCtrlBits;

    tCtrlBits ctrlQ101H, ctrlQ102H, ctrlQ103H, ctrlQ104H, ctrlQ105H;
    logic     validQ101H, validQ102H, validQ103H, validQ104H, validQ105H;
    logic     preValidQ102H, preValidQ103H, preValidQ104H, preValidQ105H;

    assign ctrlQ101H = '{aluOp: AluOpQ101H, selAluImm: SelAluImmQ101H,
                         selAluPc: SelAluPcQ101H, selNextPcJ: SelNextPcJQ101H,
                         selNextPcB: SelNextPcBQ101H, lui: LuiQ101H,
                         regWrEn: RegWrEnQ101H, dMemWrEn: DMemWrEnQ101H,
                         dMemRdEn: DMemRdEnQ101H, signExt: SignExtQ101H,
                         dMemByteEn: DMemByteEnQ101H, wbSel: WbSelQ101H,
                         branchOp: BranchOpQ101H, regDst: RegDstQ101H};

    // --------------------
    // Stage registers, each loads on its own ready
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            ctrlQ102H     <= '0;
            ctrlQ103H     <= '0;
            ctrlQ104H     <= '0;
            ctrlQ105H     <= '0;
            preValidQ102H <= 1'b0;
            preValidQ103H <= 1'b0;
            preValidQ104H <= 1'b0;
            preValidQ105H <= 1'b0;
        end else begin
            if (ReadyQ102H) begin
                ctrlQ102H     <= ctrlQ101H;
                preValidQ102H <= validQ101H;
            end
            if (ReadyQ103H) begin
                ctrlQ103H     <= ctrlQ102H;
                preValidQ103H <= validQ102H;
            end
            if (ReadyQ104H) begin
                ctrlQ104H     <= ctrlQ103H;
                preValidQ104H <= validQ103H;
            end
            if (ReadyQ105H) begin
                ctrlQ105H     <= ctrlQ104H;
                preValidQ105H <= validQ104H;
            end
        end
    end

    // Valid chain
    assign validQ101H = PreValidQ101H && ReadyQ101H;
    assign validQ102H = preValidQ102H && ReadyQ102H;
    assign validQ103H = preValidQ103H && ReadyQ103H;
    assign validQ104H = preValidQ104H && ReadyQ104H;
    assign validQ105H = preValidQ105H && ReadyQ105H;

    // --------------------
    // Stage outputs
    assign AluOpQ102H      = ctrlQ102H.aluOp;
    assign SelAluImmQ102H  = ctrlQ102H.selAluImm;
    assign SelAluPcQ102H   = ctrlQ102H.selAluPc;
    assign LuiQ102H        = ctrlQ102H.lui;
    assign BranchOpQ102H   = ctrlQ102H.branchOp;
    assign SelNextPcJQ102H = ctrlQ102H.selNextPcJ;
    assign SelNextPcBQ102H = ctrlQ102H.selNextPcB;
    assign RegDstQ102H     = ctrlQ102H.regDst;
    assign DMemRdEnQ102H   = ctrlQ102H.dMemRdEn;
    assign DMemWrEnQ103H   = ctrlQ103H.dMemWrEn;
    assign DMemRdEnQ103H   = ctrlQ103H.dMemRdEn;
    assign DMemByteEnQ103H = ctrlQ103H.dMemByteEn;
    assign RegDstQ103H     = ctrlQ103H.regDst;
    assign RegWrEnQ105H    = validQ105H && ctrlQ105H.regWrEn;  // No write from bubbles
    assign RegDstQ105H     = ctrlQ105H.regDst;
    assign WbSelQ105H      = ctrlQ105H.wbSel;
    assign SignExtQ105H    = ctrlQ105H.signExt;
    assign ByteEnQ105H     = ctrlQ105H.dMemByteEn;

    // One memory access is either a read or a write
    assert property (@(posedge Clock) disable iff (!rstN)
        !(DMemWrEnQ103H && DMemRdEnQ103H));

    cover property (@(posedge Clock) disable iff (!rstN)
        RegWrEnQ105H && (RegDstQ105H == '0));

endmodule

`default_nettype wire

/* rrvCtrl.sv */
// --------------------
// Control block top level
// Decoder, hazard unit and control pipe
// --------------------
`timescale 1ns/1ps
`default_nettype none

module rrvCtrl (
    input  wire                                Clock,
    input  wire                                rstN,
    input  wire  [rrvCorePkg::XLEN-1:0]        PreInstructionQ101H,
    input  wire                                BranchCondMetQ102H,
    input  wire                                DMemReady,
    output logic                               ReadyQ100H,
    output logic                               ReadyQ101H,
    output logic                               ReadyQ102H,
    output logic                               ReadyQ103H,
    output logic                               ReadyQ104H,
    output logic                               ReadyQ105H,
    output logic                               SelNextPcAluOutQ102H,
    output logic [rrvCorePkg::XLEN-1:0]        ImmediateQ101H,
    output logic [rrvCorePkg::REG_ADDR_W-1:0]  RegSrc1Q101H,
    output logic [rrvCorePkg::REG_ADDR_W-1:0]  RegSrc2Q101H,
    output rrvCorePkg::tAluOp                  AluOpQ102H,
    output logic                               SelAluImmQ102H,
    output logic                               SelAluPcQ102H,
    output logic                               LuiQ102H,
    output logic [2:0]                         BranchOpQ102H,
    output logic                               DMemWrEnQ103H,
    output logic                               DMemRdEnQ103H,
    output logic [3:0]                         DMemByteEnQ103H,
    output logic                               RegWrEnQ105H,
    output logic [rrvCorePkg::REG_ADDR_W-1:0]  RegDstQ105H,
    output rrvCorePkg::tWbSel                  WbSelQ105H,
    output logic                               SignExtQ105H,
    output logic [3:0]                         ByteEnQ105H
);

    // Masked instruction and Q101H control bits
    logic [rrvCorePkg::XLEN-1:0]       InstructionQ101H;
    logic                              PreValidQ101H;
    rrvCorePkg::tAluOp                 AluOpQ101H;
    logic                              SelAluImmQ101H, SelAluPcQ101H, LuiQ101H;
    logic                              SelNextPcJQ101H, SelNextPcBQ101H;
    logic                              RegWrEnQ101H, DMemWrEnQ101H, DMemRdEnQ101H;
    logic                              SignExtQ101H;
    logic [3:0]                        DMemByteEnQ101H;
    rrvCorePkg::tWbSel                 WbSelQ101H;
    logic [2:0]                        BranchOpQ101H;
    logic [rrvCorePkg::REG_ADDR_W-1:0] RegDstQ101H;

    // Feedback into the hazard unit
    logic [rrvCorePkg::REG_ADDR_W-1:0] RegDstQ102H, RegDstQ103H;
    logic                              DMemRdEnQ102H, SelNextPcJQ102H, SelNextPcBQ102H;

    rrvDecoder  i_decoder  (.*);
    rrvHazard   i_hazard   (.*);
    rrvCtrlPipe i_ctrlPipe (.*);

endmodule

`default_nettype wire

/* tbClockGen.sv */
// --------------------
// Testbench clock and reset
// 10 ns clock, rstN held low for 10 cycles
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
    output logic Clock,
    output logic rstN
);

    logic clkReg  = 1'b0;
    logic rstNReg = 1'b0;

    assign Clock = clkReg;
    assign rstN  = rstNReg;

    always #5 clkReg = ~clkReg;

    initial begin
        repeat (10) @(posedge clkReg);
        @(negedge clkReg);
        rstNReg = 1'b1;  // Released away from the rising edge
    end

endmodule

`default_nettype wire

/* tbRrvCtrl.sv */
// --------------------
// Testbench for the RV32I control block
// Stimulus and expect table, one row per cycle or run of cycles
// Checks immediates, ALU op, stalls, flushes and freeze
// Timeout counter and closing summary
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tbRrvCtrl;

    // Instruction encodings used by the table
    localparam logic [31:0] FILL     = 32'h0000_0063;  // beq x0, x0, 0
    localparam logic [31:0] ADDI_X1  = 32'h0050_0093;  // addi x1, x0, 5
    localparam logic [31:0] ADDI_X2  = 32'hFFD0_0113;  // addi x2, x0, -3
    localparam logic [31:0] SW_X2    = 32'hFE20_AC23;  // sw x2, -8(x1)
    localparam logic [31:0] BEQ_X1   = 32'hFE20_88E3;  // beq x1, x2, -16
    localparam logic [31:0] LUI_X3   = 32'h1234_51B7;  // lui x3, 0x12345
    localparam logic [31:0] JAL_X0   = 32'hFFDF_F06F;  // jal x0, -4
    localparam logic [31:0] SUB_X4   = 32'h4020_8233;  // sub x4, x1, x2
    localparam logic [31:0] SRAI_X5  = 32'h4030_D293;  // srai x5, x1, 3
    localparam logic [31:0] XOR_X6   = 32'h0020_C333;  // xor x6, x1, x2
    localparam logic [31:0] SLTIU_X7 = 32'h0010_B393;  // sltiu x7, x1, 1
    localparam logic [31:0] ADD_X8   = 32'h0020_8433;  // add x8, x1, x2
    localparam logic [31:0] LW_X5    = 32'h0000_A283;  // lw x5, 0(x1)
    localparam logic [31:0] ADD_X9   = 32'h0022_84B3;  // add x9, x5, x2

    typedef struct packed {
        logic [7:0]  testId;
        logic [31:0] instr;
        logic [31:0] pc;         // Fetch address tag, not a DUT input
        logic        branchMet;
        logic        memReady;
        logic [7:0]  reps;
        logic [5:0]  mask;       // {rWr, dWr, alu, sel, rdy, imm}
        logic [31:0] imm;
        logic        rdy;
        logic        sel;
        logic [3:0]  aluOp;
        logic        dWr;
        logic        rWr;
    } tRow;

    tRow    rows[$];
    integer seed = 32'h1d1;
    int     errCount    = 0;
    int     testErrs    = 0;
    int     testsRun    = 0;
    int     testsFailed = 0;
    int     cycleCount  = 0;
    int     cycleLimit  = 1000;

    wire         Clock;
    wire         rstN;
    logic [31:0] PreInstructionQ101H;
    logic        BranchCondMetQ102H;
    logic        DMemReady;
    wire         ReadyQ100H, ReadyQ101H, ReadyQ102H, ReadyQ103H, ReadyQ104H, ReadyQ105H;
    wire         SelNextPcAluOutQ102H;
    wire  [31:0] ImmediateQ101H;
    wire  [4:0]  RegSrc1Q101H, RegSrc2Q101H, RegDstQ105H;
    wire  [3:0]  AluOpQ102H;
    wire         SelAluImmQ102H, SelAluPcQ102H, LuiQ102H;
    wire  [2:0]  BranchOpQ102H;
    wire         DMemWrEnQ103H, DMemRdEnQ103H;
    wire  [3:0]  DMemByteEnQ103H, ByteEnQ105H;
    wire         RegWrEnQ105H, SignExtQ105H;
    wire  [1:0]  WbSelQ105H;

    tbClockGen i_clockGen (.Clock(Clock), .rstN(rstN));

    rrvCtrl i_dut (.*);

    task automatic addRow(input int testId, input logic [31:0] instr, input logic branchMet,
                          input logic memReady, input int reps, input logic [5:0] mask,
                          input logic [31:0] imm, input logic rdy, input logic sel,
                          input logic [3:0] aluOp, input logic dWr, input logic rWr);
        tRow row;
        row.testId    = testId;
        row.instr     = instr;
        row.pc        = $random(seed) & 32'hFFFF_FFFC;
        row.branchMet = branchMet;
        row.memReady  = memReady;
        row.reps      = reps;
        row.mask      = mask;
        row.imm       = imm;
        row.rdy       = rdy;
        row.sel       = sel;
        row.aluOp     = aluOp;
        row.dWr       = dWr;
        row.rWr       = rWr;
        rows.push_back(row);
    endtask

    // --------------------
    // Stimulus and expected values
    // Expected values hold in the low phase of the cycle the row is applied
    task automatic buildTable();
        addRow(1, FILL, 0, 1, 10, 6'b110100, 0, 0, 0, rrvCorePkg::ADD, 0, 0);  // Reset
        addRow(2, ADDI_X2, 0, 1, 1, 6'b000001, 32'hFFFF_FFFD, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(2, SW_X2, 0, 1, 1, 6'b000001, 32'hFFFF_FFF8, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(2, BEQ_X1, 0, 1, 1, 6'b000001, 32'hFFFF_FFF0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(2, LUI_X3, 0, 1, 1, 6'b010001, 32'h1234_5000, 0, 0, rrvCorePkg::ADD, 1, 0);
        addRow(2, JAL_X0, 0, 1, 1, 6'b100001, 32'hFFFF_FFFC, 0, 0, rrvCorePkg::ADD, 0, 1);
        addRow(2, FILL, 0, 1, 1, 6'b000111, 0, 1, 1, rrvCorePkg::ADD, 0, 0);   // JAL redirect
        addRow(2, FILL, 0, 1, 1, 6'b000111, 0, 1, 0, rrvCorePkg::ADD, 0, 0);
        addRow(3, SUB_X4, 0, 1, 1, 6'b000000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(3, SRAI_X5, 0, 1, 1, 6'b001000, 0, 0, 0, rrvCorePkg::SUB, 0, 0);
        addRow(3, XOR_X6, 0, 1, 1, 6'b001000, 0, 0, 0, rrvCorePkg::SRA, 0, 0);
        addRow(3, SLTIU_X7, 0, 1, 1, 6'b001000, 0, 0, 0, rrvCorePkg::XOR, 0, 0);
        addRow(3, SW_X2, 0, 1, 1, 6'b001000, 0, 0, 0, rrvCorePkg::SLTU, 0, 0);
        addRow(3, ADD_X8, 0, 1, 1, 6'b011000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(3, FILL, 0, 1, 1, 6'b011000, 0, 0, 0, rrvCorePkg::ADD, 1, 0);   // Store at Q103H
        addRow(3, FILL, 0, 1, 1, 6'b000000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(3, FILL, 0, 1, 1, 6'b100000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(3, FILL, 0, 1, 1, 6'b100000, 0, 0, 0, rrvCorePkg::ADD, 0, 1);   // ADD retires
        addRow(4, LW_X5, 0, 1, 1, 6'b000010, 0, 1, 0, rrvCorePkg::ADD, 0, 0);
        addRow(4, ADD_X9, 0, 1, 2, 6'b000010, 0, 0, 0, rrvCorePkg::ADD, 0, 0);  // Two bubbles
        addRow(4, ADD_X9, 0, 1, 1, 6'b000010, 0, 1, 0, rrvCorePkg::ADD, 0, 0);
        addRow(4, FILL, 0, 1, 1, 6'b100010, 0, 1, 0, rrvCorePkg::ADD, 0, 1);
        addRow(4, FILL, 0, 1, 2, 6'b100000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(4, FILL, 0, 1, 1, 6'b100000, 0, 0, 0, rrvCorePkg::ADD, 0, 1);
        addRow(5, BEQ_X1, 0, 1, 1, 6'b000100, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(5, ADD_X8, 1, 1, 1, 6'b000110, 0, 1, 1, rrvCorePkg::ADD, 0, 0);  // Taken
        addRow(5, ADD_X8, 0, 1, 1, 6'b000110, 0, 1, 0, rrvCorePkg::ADD, 0, 0);
        addRow(5, ADDI_X1, 0, 1, 1, 6'b000000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(5, BEQ_X1, 0, 1, 1, 6'b000000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(5, ADD_X8, 0, 1, 1, 6'b100100, 0, 0, 0, rrvCorePkg::ADD, 0, 0);  // Not taken
        addRow(5, FILL, 0, 1, 1, 6'b100000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(5, FILL, 0, 1, 1, 6'b100000, 0, 0, 0, rrvCorePkg::ADD, 0, 1);
        addRow(5, FILL, 0, 1, 1, 6'b100000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(5, FILL, 0, 1, 1, 6'b100000, 0, 0, 0, rrvCorePkg::ADD, 0, 1);
        addRow(6, ADD_X8, 0, 1, 1, 6'b000000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(6, FILL, 0, 1, 3, 6'b100000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
        addRow(6, FILL, 0, 0, 3, 6'b100010, 0, 0, 0, rrvCorePkg::ADD, 0, 0);   // Frozen
        addRow(6, FILL, 0, 1, 1, 6'b100010, 0, 1, 0, rrvCorePkg::ADD, 0, 1);   // ADD held
        addRow(6, FILL, 0, 1, 1, 6'b100000, 0, 0, 0, rrvCorePkg::ADD, 0, 0);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp, input tRow row);
        $display("** Error test %0d pc 0x%h: %s got 0x%h expected 0x%h",
                 row.testId, row.pc, name, got, exp);
        errCount++;
        testErrs++;
    endtask

    task automatic checkRow(input tRow row);
        if (row.mask[0] && ImmediateQ101H !== row.imm)
            reportMismatch("ImmediateQ101H", ImmediateQ101H, row.imm, row);
        if (row.mask[0] && RegSrc1Q101H !== row.instr[19:15])
            reportMismatch("RegSrc1Q101H", RegSrc1Q101H, row.instr[19:15], row);
        if (row.mask[0] && RegSrc2Q101H !== row.instr[24:20])
            reportMismatch("RegSrc2Q101H", RegSrc2Q101H, row.instr[24:20], row);
        if (row.mask[1] && ReadyQ101H !== row.rdy)
            reportMismatch("ReadyQ101H", ReadyQ101H, row.rdy, row);
        if (row.mask[1] && ReadyQ100H !== row.rdy)
            reportMismatch("ReadyQ100H", ReadyQ100H, row.rdy, row);
        if (row.mask[2] && SelNextPcAluOutQ102H !== row.sel)
            reportMismatch("SelNextPcAluOutQ102H", SelNextPcAluOutQ102H, row.sel, row);
        if (row.mask[3] && AluOpQ102H !== row.aluOp)
            reportMismatch("AluOpQ102H", AluOpQ102H, row.aluOp, row);
        if (row.mask[4] && DMemWrEnQ103H !== row.dWr)
            reportMismatch("DMemWrEnQ103H", DMemWrEnQ103H, row.dWr, row);
        if (row.mask[5] && RegWrEnQ105H !== row.rWr)
            reportMismatch("RegWrEnQ105H", RegWrEnQ105H, row.rWr, row);
        // Frozen pipe keeps the add x8 at Q105H, ALU write-back of a full register
        if (!row.memReady && {RegDstQ105H, WbSelQ105H, SignExtQ105H, ByteEnQ105H} !==
                             {ADD_X8[11:7], 2'd0, 1'b0, 4'd0})
            reportMismatch("{RegDstQ105H,WbSelQ105H,SignExtQ105H,ByteEnQ105H}",
                           {RegDstQ105H, WbSelQ105H, SignExtQ105H, ByteEnQ105H},
                           {ADD_X8[11:7], 2'd0, 1'b0, 4'd0}, row);
        // Back stages follow DMemReady alone
        if ({ReadyQ105H, ReadyQ104H, ReadyQ103H, ReadyQ102H} !== {4{row.memReady}})
            reportMismatch("ReadyQ105H..ReadyQ102H",
                           {ReadyQ105H, ReadyQ104H, ReadyQ103H, ReadyQ102H},
                           {4{row.memReady}}, row);
    endtask

    task automatic reportTest(input int testId);
        testsRun++;
        if (testErrs == 0) begin
            $display("Test %0d: pass", testId);
        end else begin
            $display("Test %0d: FAIL with %0d mismatches", testId, testErrs);
            testsFailed++;
        end
        testErrs = 0;
    endtask

    // --------------------
    // Main sequence
    initial begin
        tRow row;
        int  curTest;
        int  totalCycles;
        PreInstructionQ101H = FILL;
        BranchCondMetQ102H  = 1'b0;
        DMemReady           = 1'b1;
        buildTable();
        totalCycles = 0;
        foreach (rows[i])
            totalCycles += rows[i].reps;
        cycleLimit = totalCycles + 30;
        curTest    = rows[0].testId;
        @(posedge Clock);  // Align to the first full cycle
        foreach (rows[i]) begin
            row = rows[i];
            if (row.testId != curTest) begin
                reportTest(curTest);
                curTest = row.testId;
            end
            repeat (row.reps) begin
                @(negedge Clock);
                PreInstructionQ101H = row.instr;
                BranchCondMetQ102H  = row.branchMet;
                DMemReady           = row.memReady;
                #3;  // Mid low phase, inputs settled
                checkRow(row);
            end
        end
        reportTest(curTest);
        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Run limit
    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Errors found");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
rrvCorePkg.sv
rrvDecoder.sv
rrvHazard.sv
rrvCtrlPipe.sv
rrvCtrl.sv
tbClockGen.sv
tbRrvCtrl.sv
